// ==== Bender.yml ====
package:
  name: pipeline

sources:
  - verilog/isa_pkg.sv
  - verilog/pipe_pkg.sv
  - verilog/decoder.sv
  - verilog/reg_file.sv
  - verilog/execute_stage.sv
  - verilog/hazard_unit.sv
  - verilog/pipeline.sv
  - target: simulation
    files:
      - verif/pipeline_props.sv
      - verif/pipeline_tb.sv

// ==== flist.f ====
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/decoder.sv
verilog/reg_file.sv
verilog/execute_stage.sv
verilog/hazard_unit.sv
verilog/pipeline.sv
verif/pipeline_props.sv
verif/pipeline_tb.sv

// ==== verif/pipeline_props.sv ====
`timescale 1ns/1ps

module pipeline_props
    import isa_pkg::*;
(
    input logic  ui_clk_from_ddr,
    input logic  reset,
    input word_t imem_addr,
    input logic  dmem_read,
    input logic  dmem_write
);

    // One memory access per cycle
    no_read_and_write: assert property (@(posedge ui_clk_from_ddr) disable iff (reset)
        !(dmem_read && dmem_write))
        else $error("dmem_read and dmem_write high in the same cycle");

    write_known: assert property (@(posedge ui_clk_from_ddr) disable iff (reset)
        !$isunknown(dmem_write))
        else $error("dmem_write is unknown");

    fetch_aligned: assert property (@(posedge ui_clk_from_ddr) disable iff (reset)
        !$isunknown(imem_addr) && imem_addr[1:0] == 2'b00)
        else $error("imem_addr is unknown or not word aligned");

endmodule

bind pipeline pipeline_props pipeline_props_inst (
    .ui_clk_from_ddr ( ui_clk_from_ddr ),
    .reset           ( reset           ),
    .imem_addr       ( imem_addr       ),
    .dmem_read       ( dmem_read       ),
    .dmem_write      ( dmem_write      )
);

// ==== verif/pipeline_tb.sv ====
`timescale 1ns/1ps

module pipeline_tb
    import isa_pkg::*;
();

    localparam int prog_len   = 64;
    localparam int data_words = 64;
    localparam int max_cycles = 2000;

    logic  ui_clk_from_ddr;
    logic  reset;
    word_t imem_addr;
    word_t imem_data;
    word_t dmem_addr;
    logic  dmem_read;
    logic  dmem_write;
    word_t dmem_wdata;
    word_t dmem_rdata;

    word_t       program_mem [prog_len];
    word_t       dmem [data_words];
    word_t       ref_mem [data_words];
    word_t       ref_regs [reg_count];
    word_t       exp_addr [$];
    word_t       exp_data [$];
    word_t       exp_load [$];
    logic [31:0] rng_state;
    int          errors;
    int          store_count;
    int          load_count;
    int          cycles;

    pipeline pipeline_inst (
        .ui_clk_from_ddr ( ui_clk_from_ddr ),
        .reset           ( reset           ),
        .imem_addr       ( imem_addr       ),
        .imem_data       ( imem_data       ),
        .dmem_addr       ( dmem_addr       ),
        .dmem_read       ( dmem_read       ),
        .dmem_write      ( dmem_write      ),
        .dmem_wdata      ( dmem_wdata      ),
        .dmem_rdata      ( dmem_rdata      )
    );

    initial ui_clk_from_ddr = 1'b0;
    always #5 ui_clk_from_ddr = ~ui_clk_from_ddr;

    // Initial data memory contents, different for every word
    function automatic word_t fill_word(int idx);
        return (idx * 32'h9e37_79b9) ^ 32'h5a0f_c3e1;
    endfunction

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic word_t enc_r(funct_e fn, reg_addr_t rs, reg_addr_t rt, reg_addr_t rd);
        return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t enc_i(opcode_e op, reg_addr_t rs, reg_addr_t rt, imm_t imm);
        return {op, rs, rt, imm};
    endfunction

    ////////////////////////////////////////
    // Program generation
    ////////////////////////////////////////

    task automatic gen_program();
        logic [31:0] r;
        logic [31:0] f;
        int          sel;
        int          skip;
        for (int i = 0; i < prog_len - 1; i++) begin
            r    = next_rand();
            f    = next_rand();
            sel  = r % 20;
            skip = 1 + r[9:8];
            if (sel < 7) begin
                case (f[26:24] % 6)
                    0: program_mem[i] = enc_r(FN_ADDU, f[2:0], f[5:3], f[8:6]);
                    1: program_mem[i] = enc_r(FN_SUBU, f[2:0], f[5:3], f[8:6]);
                    2: program_mem[i] = enc_r(FN_AND, f[2:0], f[5:3], f[8:6]);
                    3: program_mem[i] = enc_r(FN_OR, f[2:0], f[5:3], f[8:6]);
                    4: program_mem[i] = enc_r(FN_XOR, f[2:0], f[5:3], f[8:6]);
                    default: program_mem[i] = enc_r(FN_SLT, f[2:0], f[5:3], f[8:6]);
                endcase
            end else if (sel < 11) begin
                case (f[23:22])
                    0: program_mem[i] = enc_i(OP_ADDIU, f[2:0], f[5:3], f[31:16]);
                    1: program_mem[i] = enc_i(OP_ANDI, f[2:0], f[5:3], f[31:16]);
                    2: program_mem[i] = enc_i(OP_ORI, f[2:0], f[5:3], f[31:16]);
                    default: program_mem[i] = enc_i(OP_LUI, 5'd0, f[5:3], f[31:16]);
                endcase
            end else if (sel < 14) begin
                // Base is $0, so the word index is the offset
                program_mem[i] = enc_i(OP_LW, 5'd0, f[5:3], {8'd0, f[21:16], 2'b00});
            end else if (sel < 17) begin
                program_mem[i] = enc_i(OP_SW, 5'd0, f[5:3], {8'd0, f[21:16], 2'b00});
            end else if (i + 1 + skip <= prog_len - 1) begin
                case (f[23:22])
                    0: program_mem[i] = enc_i(OP_BEQ, f[2:0], f[5:3], imm_t'(skip));
                    1: program_mem[i] = enc_i(OP_BNE, f[2:0], f[5:3], imm_t'(skip));
                    2: program_mem[i] = {OP_J, 26'(i + 1 + skip)};
                    default: program_mem[i] = enc_i(OP_BEQ, f[2:0], f[2:0], imm_t'(skip));
                endcase
            end else begin
                program_mem[i] = enc_i(OP_ADDIU, f[2:0], f[5:3], f[31:16]);
            end
        end
        // Final spin loop
        program_mem[prog_len-1] = {OP_J, 26'(prog_len - 1)};
    endtask

    ////////////////////////////////////////
    // Reference interpreter
    ////////////////////////////////////////

    task automatic run_reference();
        int        pc;
        int        steps;
        word_t     w;
        word_t     a;
        word_t     b;
        word_t     simm;
        word_t     zimm;
        word_t     addr;
        reg_addr_t rt;
        reg_addr_t rd;
        for (int i = 0; i < reg_count; i++) begin
            ref_regs[i] = '0;
        end
        for (int i = 0; i < data_words; i++) begin
            ref_mem[i] = fill_word(i);
        end
        pc    = 0;
        steps = 0;
        while (pc != prog_len - 1 && steps < 1000) begin
            w     = program_mem[pc];
            a     = ref_regs[w[25:21]];
            b     = ref_regs[w[20:16]];
            rt    = w[20:16];
            rd    = w[15:11];
            simm  = {{16{w[15]}}, w[15:0]};
            zimm  = {16'd0, w[15:0]};
            addr  = a + simm;
            pc    = pc + 1;
            steps = steps + 1;
            case (w[31:26])
                OP_RTYPE: begin
                    case (w[5:0])
                        FN_ADDU: ref_regs[rd] = a + b;
                        FN_SUBU: ref_regs[rd] = a - b;
                        FN_AND:  ref_regs[rd] = a & b;
                        FN_OR:   ref_regs[rd] = a | b;
                        FN_XOR:  ref_regs[rd] = a ^ b;
                        FN_SLT:  ref_regs[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: ;
                    endcase
                end
                OP_ADDIU: ref_regs[rt] = a + simm;
                OP_ANDI:  ref_regs[rt] = a & zimm;
                OP_ORI:   ref_regs[rt] = a | zimm;
                OP_LUI:   ref_regs[rt] = {w[15:0], 16'd0};
                OP_LW: begin
                    exp_load.push_back(addr);
                    ref_regs[rt] = ref_mem[addr[7:2]];
                end
                OP_SW: begin
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                    ref_mem[addr[7:2]] = b;
                end
                OP_BEQ: if (a == b) pc = pc + $signed(simm);
                OP_BNE: if (a != b) pc = pc + $signed(simm);
                OP_J:   pc = w[25:0];
                default: ;
            endcase
            ref_regs[0] = '0;
        end
    endtask

    task automatic check_store();
        if (store_count >= exp_addr.size()) begin
            errors++;
            $display("ERROR %0t: unexpected store %0d of %h to %h", $time, store_count,
                     dmem_wdata, dmem_addr);
        end else if (dmem_addr !== exp_addr[store_count] ||
                     dmem_wdata !== exp_data[store_count]) begin
            errors++;
            $display("ERROR %0t: store %0d wrote %h to %h, expected %h to %h", $time,
                     store_count, dmem_wdata, dmem_addr, exp_data[store_count],
                     exp_addr[store_count]);
        end
        dmem[dmem_addr[7:2]] = dmem_wdata;
        store_count++;
    endtask

    task automatic check_load();
        if (load_count >= exp_load.size()) begin
            errors++;
            $display("ERROR %0t: unexpected load %0d from %h", $time, load_count,
                     dmem_addr);
        end else if (dmem_addr !== exp_load[load_count]) begin
            errors++;
            $display("ERROR %0t: load %0d read from %h, expected %h", $time, load_count,
                     dmem_addr, exp_load[load_count]);
        end
        load_count++;
    endtask

    // Memory models, updated once the MEM stage outputs have settled
    always @(posedge ui_clk_from_ddr) begin
        #1;
        if (reset) begin
            if (dmem_write !== 1'b0 || dmem_read !== 1'b0) begin
                errors++;
                $display("ERROR %0t: dmem_write %b, dmem_read %b during reset", $time,
                         dmem_write, dmem_read);
            end
        end else begin
            if (dmem_write === 1'b1) begin
                check_store();
            end
            if (dmem_read === 1'b1) begin
                check_load();
            end
        end
        imem_data  <= (imem_addr < prog_len * 4) ? program_mem[imem_addr[7:2]] : '0;
        dmem_rdata <= dmem[dmem_addr[7:2]];
    end

    initial begin
        reset       = 1'b1;
        imem_data   = '0;
        dmem_rdata  = '0;
        errors      = 0;
        store_count = 0;
        load_count  = 0;
        rng_state   = 32'h9cf2_6c8a;
        for (int i = 0; i < data_words; i++) begin
            dmem[i] = fill_word(i);
        end
        gen_program();
        run_reference();

        repeat (16) @(posedge ui_clk_from_ddr);
        #1;
        if (imem_addr !== '0) begin
            errors++;
            $display("ERROR %0t: first fetch at %h, expected 0", $time, imem_addr);
        end
        reset <= 1'b0;

        cycles = 0;
        while (store_count < exp_addr.size() && cycles < max_cycles) begin
            @(posedge ui_clk_from_ddr);
            cycles++;
        end
        if (store_count < exp_addr.size()) begin
            errors++;
            $display("Timeout: only %0d of %0d expected stores seen after %0d cycles",
                     store_count, exp_addr.size(), cycles);
        end else begin
            // Anything stored from here on is extra
            repeat (40) @(posedge ui_clk_from_ddr);
            #2;
            if (load_count != exp_load.size()) begin
                errors++;
                $display("Load count wrong: saw %0d loads, expected %0d", load_count,
                         exp_load.size());
            end
        end

        $display("Stores seen %0d, expected %0d, loads seen %0d, expected %0d, errors %0d",
                 store_count, exp_addr.size(), load_count, exp_load.size(), errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== verilog/decoder.sv ====
`timescale 1ns/1ps

module decoder
    import isa_pkg::*, pipe_pkg::*;
(
    input  word_t instr,
    output ctrl_t ctrl
);

    opcode_e   opcode;
    funct_e    funct;
    reg_addr_t dest_field;

    assign opcode = opcode_e'(instr[31:26]);
    assign funct  = funct_e'(instr[5:0]);

    always_comb begin
        ctrl = ctrl_nop;
        case (opcode)
            OP_RTYPE: begin
                ctrl.reg_write = 1'b1;
                case (funct)
                    FN_ADDU: ctrl.alu_op = ALU_ADD;
                    FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_XOR:  ctrl.alu_op = ALU_XOR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    // Unknown funct, sll $0 included
                    default: ctrl = ctrl_nop;
                endcase
            end
            OP_ADDIU, OP_ANDI, OP_ORI, OP_LUI, OP_LW: begin
                ctrl.reg_write  = 1'b1;
                ctrl.b_is_imm   = 1'b1;
                ctrl.dest_is_rt = 1'b1;
                case (opcode)
                    OP_ANDI: begin
                        ctrl.alu_op       = ALU_AND;
                        ctrl.imm_zero_ext = 1'b1;
                    end
                    OP_ORI: begin
                        ctrl.alu_op       = ALU_OR;
                        ctrl.imm_zero_ext = 1'b1;
                    end
                    OP_LUI:  ctrl.alu_op = ALU_LUI;
                    default: ctrl.alu_op = ALU_ADD;
                endcase
                ctrl.mem_read = (opcode == OP_LW);
            end
            OP_SW: begin
                ctrl.mem_write = 1'b1;
                ctrl.b_is_imm  = 1'b1;
            end
            OP_BEQ: ctrl.branch_eq = 1'b1;
            OP_BNE: ctrl.branch_ne = 1'b1;
            OP_J:   ctrl.jump      = 1'b1;
            default: ctrl = ctrl_nop;
        endcase

        // Writes to $0 are dropped here
        dest_field = ctrl.dest_is_rt ? instr[20:16] : instr[15:11];
        if (dest_field == '0) begin
            ctrl.reg_write = 1'b0;
        end
    end

endmodule

// ==== verilog/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage
    import isa_pkg::*, pipe_pkg::*;
(
    input  id_ex_t   idex,
    input  ex_mem_t  exmem_fwd,
    input  word_t    wb_value,
    input  fwd_sel_e forward_a,
    input  fwd_sel_e forward_b,
    output ex_mem_t  exmem_next,
    output logic     redirect,
    output word_t    redirect_target
);

    word_t op_a;
    word_t op_b_fwd;
    word_t op_b;
    word_t alu_result;
    logic  operands_equal;

    function automatic word_t fwd_mux(fwd_sel_e sel, word_t reg_val, word_t mem_val,
                                      word_t wb_val);
        case (sel)
            FWD_EXMEM: return mem_val;
            FWD_MEMWB: return wb_val;
            default:   return reg_val;
        endcase
    endfunction

    ////////////////////////////////////////
    // Operands
    ////////////////////////////////////////

    assign op_a     = fwd_mux(forward_a, idex.rs_val, exmem_fwd.alu_result, wb_value);
    assign op_b_fwd = fwd_mux(forward_b, idex.rt_val, exmem_fwd.alu_result, wb_value);
    assign op_b     = idex.ctrl.b_is_imm ? idex.imm_ext : op_b_fwd;

    ////////////////////////////////////////
    // ALU
    ////////////////////////////////////////

    always_comb begin
        case (idex.ctrl.alu_op)
            ALU_ADD: alu_result = op_a + op_b;
            ALU_SUB: alu_result = op_a - op_b;
            ALU_AND: alu_result = op_a & op_b;
            ALU_OR:  alu_result = op_a | op_b;
            ALU_XOR: alu_result = op_a ^ op_b;
            ALU_SLT: alu_result = {31'd0, $signed(op_a) < $signed(op_b)};
            ALU_LUI: alu_result = {op_b[15:0], 16'd0};
            default: alu_result = '0;
        endcase
    end

    // Branches compare the forwarded registers, never the immediate
    assign operands_equal  = (op_a == op_b_fwd);
    assign redirect        = (idex.ctrl.branch_eq && operands_equal) ||
                             (idex.ctrl.branch_ne && !operands_equal);
    assign redirect_target = idex.pc_plus4 + {idex.imm_ext[29:0], 2'b00};

    always_comb begin
        exmem_next.alu_result = alu_result;
        exmem_next.store_data = op_b_fwd;
        exmem_next.dest       = idex.dest;
        exmem_next.mem_read   = idex.ctrl.mem_read;
        exmem_next.mem_write  = idex.ctrl.mem_write;
        exmem_next.reg_write  = idex.ctrl.reg_write;
    end

endmodule

// ==== verilog/hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit
    import isa_pkg::*, pipe_pkg::*;
(
    input  reg_addr_t ifid_rs,
    input  reg_addr_t ifid_rt,
    input  reg_addr_t idex_rs,
    input  reg_addr_t idex_rt,
    input  reg_addr_t idex_dest,
    input  logic      idex_mem_read,
    input  reg_addr_t exmem_dest,
    input  reg_addr_t memwb_dest,
    input  logic      exmem_reg_write,
    input  logic      memwb_reg_write,
    input  logic      id_jump,
    input  logic      redirect,
    output fwd_sel_e  forward_a,
    output fwd_sel_e  forward_b,
    output logic      pc_stall,
    output logic      ifid_stall,
    output logic      ifid_flush,
    output logic      idex_flush
);

    logic load_use;

    // Youngest producer first
    function automatic fwd_sel_e pick_source(reg_addr_t src);
        if (src == '0) begin
            return FWD_REG;
        end
        if (exmem_reg_write && exmem_dest == src) begin
            return FWD_EXMEM;
        end
        if (memwb_reg_write && memwb_dest == src) begin
            return FWD_MEMWB;
        end
        return FWD_REG;
    endfunction

    always_comb begin
        forward_a = pick_source(idex_rs);
        forward_b = pick_source(idex_rt);
    end

    ////////////////////////////////////////
    // Stall and flush
    ////////////////////////////////////////

    assign load_use = idex_mem_read && idex_dest != '0 &&
                      (idex_dest == ifid_rs || idex_dest == ifid_rt);

    // A taken branch in EX overrides everything younger
    assign pc_stall   = load_use && !redirect;
    assign ifid_stall = load_use && !redirect;
    assign ifid_flush = redirect || (id_jump && !load_use);
    assign idex_flush = redirect || load_use;

endmodule

// ==== verilog/isa_pkg.sv ====
package isa_pkg;

    ////////////////////////////////////////
    // Field widths
    ////////////////////////////////////////

    localparam int word_width     = 32;
    localparam int reg_addr_width = 5;
    localparam int imm_width      = 16;
    localparam int opcode_width   = 6;
    localparam int funct_width    = 6;

    // General purpose registers, $0 included
    localparam int reg_count = 32;

    typedef logic [word_width-1:0]     word_t;
    typedef logic [reg_addr_width-1:0] reg_addr_t;
    typedef logic [imm_width-1:0]      imm_t;

    ////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////

    // Primary opcode, instr[31:26]
    typedef enum logic [opcode_width-1:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDIU = 6'h09,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    // Function field of R-type, instr[5:0]
    typedef enum logic [funct_width-1:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } funct_e;

endpackage

// ==== verilog/pipe_pkg.sv ====
package pipe_pkg;

    import isa_pkg::*;

    // Fetch address out of reset
    localparam word_t reset_pc = '0;

    ////////////////////////////////////////
    // Control encodings
    ////////////////////////////////////////

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI
    } alu_op_e;

    // Operand source in EX
    typedef enum logic [1:0] {
        FWD_REG,
        FWD_EXMEM,
        FWD_MEMWB
    } fwd_sel_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    b_is_imm;
        logic    imm_zero_ext;
        logic    mem_read;
        logic    mem_write;
        logic    reg_write;
        logic    branch_eq;
        logic    branch_ne;
        logic    jump;
        logic    dest_is_rt;
    } ctrl_t;

    // No writes, no redirect
    localparam ctrl_t ctrl_nop = '0;

    ////////////////////////////////////////
    // Stage registers
    ////////////////////////////////////////

    typedef struct packed {
        word_t     pc_plus4;
        ctrl_t     ctrl;
        word_t     rs_val;
        word_t     rt_val;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t dest;
        word_t     imm_ext;
    } id_ex_t;

    typedef struct packed {
        word_t     alu_result;
        word_t     store_data;
        reg_addr_t dest;
        logic      mem_read;
        logic      mem_write;
        logic      reg_write;
    } ex_mem_t;

    typedef struct packed {
        word_t     alu_result;
        word_t     load_data;
        reg_addr_t dest;
        logic      mem_read;
        logic      reg_write;
    } mem_wb_t;

endpackage

// ==== verilog/pipeline.sv ====
`timescale 1ns/1ps

module pipeline
    import isa_pkg::*, pipe_pkg::*;
(
    input  logic  ui_clk_from_ddr,
    input  logic  reset,
    output word_t imem_addr,
    input  word_t imem_data,
    output word_t dmem_addr,
    output logic  dmem_read,
    output logic  dmem_write,
    output word_t dmem_wdata,
    input  word_t dmem_rdata
);

    word_t     pc;
    word_t     pc_plus4;
    word_t     pc_next;
    word_t     jump_target;
    word_t     ifid_instr;
    word_t     ifid_pc_plus4;
    ctrl_t     id_ctrl;
    reg_addr_t id_rs;
    reg_addr_t id_rt;
    reg_addr_t id_rd;
    reg_addr_t id_dest;
    imm_t      id_imm;
    word_t     id_rs_val;
    word_t     id_rt_val;
    word_t     id_imm_ext;
    id_ex_t    idex;
    ex_mem_t   exmem_next;
    ex_mem_t   exmem;
    mem_wb_t   memwb;
    word_t     wb_value;
    word_t     redirect_target;
    logic      redirect;
    fwd_sel_e  forward_a;
    fwd_sel_e  forward_b;
    logic      pc_stall;
    logic      ifid_stall;
    logic      ifid_flush;
    logic      idex_flush;

    ////////////////////////////////////////
    // IF
    ////////////////////////////////////////

    assign pc_plus4    = pc + 32'd4;
    assign jump_target = {ifid_pc_plus4[31:28], ifid_instr[25:0], 2'b00};
    assign imem_addr   = pc;

    // Branch in EX beats jump in ID
    always_comb begin
        if (redirect) begin
            pc_next = redirect_target;
        end else if (id_ctrl.jump) begin
            pc_next = jump_target;
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_ff @(posedge ui_clk_from_ddr) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (!pc_stall) begin
            pc <= pc_next;
        end
    end

    // Zero word decodes as a bubble
    always_ff @(posedge ui_clk_from_ddr) begin
        if (reset || ifid_flush) begin
            ifid_instr    <= '0;
            ifid_pc_plus4 <= '0;
        end else if (!ifid_stall) begin
            ifid_instr    <= imem_data;
            ifid_pc_plus4 <= pc_plus4;
        end
    end

    ////////////////////////////////////////
    // ID
    ////////////////////////////////////////

    assign id_rs   = ifid_instr[25:21];
    assign id_rt   = ifid_instr[20:16];
    assign id_rd   = ifid_instr[15:11];
    assign id_imm  = ifid_instr[15:0];
    assign id_dest = id_ctrl.dest_is_rt ? id_rt : id_rd;

    assign id_imm_ext = id_ctrl.imm_zero_ext ? {16'd0, id_imm} : {{16{id_imm[15]}}, id_imm};

    decoder decoder_inst (
        .instr ( ifid_instr ),
        .ctrl  ( id_ctrl    )
    );

    reg_file reg_file_inst (
        .ui_clk_from_ddr ( ui_clk_from_ddr ),
        .reset           ( reset           ),
        .rs_addr         ( id_rs           ),
        .rt_addr         ( id_rt           ),
        .rd_addr         ( memwb.dest      ),
        .rd_write        ( memwb.reg_write ),
        .rd_data         ( wb_value        ),
        .rs_data         ( id_rs_val       ),
        .rt_data         ( id_rt_val       )
    );

    always_ff @(posedge ui_clk_from_ddr) begin
        if (reset || idex_flush) begin
            idex <= '0;
        end else begin
            idex <= '{pc_plus4: ifid_pc_plus4, ctrl: id_ctrl, rs_val: id_rs_val,
                      rt_val: id_rt_val, rs: id_rs, rt: id_rt, dest: id_dest,
                      imm_ext: id_imm_ext};
        end
    end

    ////////////////////////////////////////
    // EX
    ////////////////////////////////////////

    execute_stage execute_stage_inst (
        .idex            ( idex            ),
        .exmem_fwd       ( exmem           ),
        .wb_value        ( wb_value        ),
        .forward_a       ( forward_a       ),
        .forward_b       ( forward_b       ),
        .exmem_next      ( exmem_next      ),
        .redirect        ( redirect        ),
        .redirect_target ( redirect_target )
    );

    always_ff @(posedge ui_clk_from_ddr) begin
        if (reset) begin
            exmem <= '0;
        end else begin
            exmem <= exmem_next;
        end
    end

    ////////////////////////////////////////
    // MEM and WB
    ////////////////////////////////////////

    assign dmem_addr  = exmem.alu_result;
    assign dmem_read  = exmem.mem_read;
    assign dmem_write = exmem.mem_write;
    assign dmem_wdata = exmem.store_data;

    always_ff @(posedge ui_clk_from_ddr) begin
        if (reset) begin
            memwb <= '0;
        end else begin
            memwb <= '{alu_result: exmem.alu_result, load_data: dmem_rdata,
                       dest: exmem.dest, mem_read: exmem.mem_read,
                       reg_write: exmem.reg_write};
        end
    end

    assign wb_value = memwb.mem_read ? memwb.load_data : memwb.alu_result;

    hazard_unit hazard_unit_inst (
        .ifid_rs         ( id_rs           ),
        .ifid_rt         ( id_rt           ),
        .idex_rs         ( idex.rs         ),
        .idex_rt         ( idex.rt         ),
        .idex_dest       ( idex.dest       ),
        .idex_mem_read   ( idex.ctrl.mem_read ),
        .exmem_dest      ( exmem.dest      ),
        .memwb_dest      ( memwb.dest      ),
        .exmem_reg_write ( exmem.reg_write ),
        .memwb_reg_write ( memwb.reg_write ),
        .id_jump         ( id_ctrl.jump    ),
        .redirect        ( redirect        ),
        .forward_a       ( forward_a       ),
        .forward_b       ( forward_b       ),
        .pc_stall        ( pc_stall        ),
        .ifid_stall      ( ifid_stall      ),
        .ifid_flush      ( ifid_flush      ),
        .idex_flush      ( idex_flush      )
    );

endmodule

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ps

module reg_file
    import isa_pkg::*;
(
    input  logic      ui_clk_from_ddr,
    input  logic      reset,
    input  reg_addr_t rs_addr,
    input  reg_addr_t rt_addr,
    input  reg_addr_t rd_addr,
    input  logic      rd_write,
    input  word_t     rd_data,
    output word_t     rs_data,
    output word_t     rt_data
);

    word_t regs [reg_count];

    // $0 reads zero, a write in flight is seen at once
    function automatic word_t read_port(reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (rd_write && rd_addr == addr) begin
            return rd_data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs_data = read_port(rs_addr);
        rt_data = read_port(rt_addr);
    end

    always_ff @(posedge ui_clk_from_ddr) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_write && rd_addr != '0) begin
            regs[rd_addr] <= rd_data;
        end
    end

endmodule
